// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module legBackEndTb \
		-f legBackEnd.f -Mdir obj_dir
	./obj_dir/VlegBackEndTb | tee $(LOG)
	@grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: legBackEnd.f
rtl/legPkg.sv
rtl/aluControl.sv
rtl/executeStage.sv
rtl/memoryAccess.sv
rtl/legBackEnd.sv
test/legBackEnd_checker.sv
test/legBackEndTb.sv

// File: rtl/aluControl.sv
`timescale 1ns/1ps

module aluControl
(
  input  legPkg::aluOpT   aluOp,
  input  logic [10:0]     opcode,
  output legPkg::aluFuncT func
);

  always_comb
  begin
    func = legPkg::aluAdd;
    case (aluOp)
      2'd0: func = legPkg::aluAdd;
      2'd1: func = legPkg::aluPassB;
      2'd2:
      begin
        case (opcode)
          11'b10001011000: func = legPkg::aluAdd;
          11'b11001011000: func = legPkg::aluSub;
          11'b10001010000: func = legPkg::aluAnd;
          11'b10101010000: func = legPkg::aluOrr;
          default:         func = legPkg::aluAdd;
        endcase
      end
      default:
      begin
        // I-type opcodes are only ten bits wide
        case (opcode[10:1])
          10'b1001000100: func = legPkg::aluAdd;
          10'b1101000100: func = legPkg::aluSub;
          10'b1001001000: func = legPkg::aluAnd;
          10'b1011001000: func = legPkg::aluOrr;
          default:        func = legPkg::aluAdd;
        endcase
      end
    endcase
  end

endmodule

// File: rtl/executeStage.sv
`timescale 1ns/1ps

module executeStage
(
  input  logic               clk,
  input  logic               rst,
  input  logic               inValid,
  input  legPkg::doubleWordT pc,
  input  legPkg::instrT      instr,
  input  legPkg::doubleWordT signExt,
  input  legPkg::doubleWordT readData1,
  input  legPkg::doubleWordT readData2,
  input  legPkg::aluSrcT     aluSrc,
  input  legPkg::aluOpT      aluOp,
  input  logic               branch,
  input  logic               branchZero,
  input  logic               branchNotZero,
  input  logic               memRead,
  input  logic               memWrite,
  input  logic               memToReg,
  input  logic               regWrite,
  output logic               exValid,
  output legPkg::regIdT      exInstrReg,
  output legPkg::doubleWordT exResult,
  output legPkg::doubleWordT exStoreData,
  output logic               exZero,
  output legPkg::doubleWordT exBranchTarget,
  output logic               exBranch,
  output logic               exBranchZero,
  output logic               exBranchNotZero,
  output logic               exMemRead,
  output logic               exMemWrite,
  output logic               exMemToReg,
  output logic               exRegWrite
);

  // --------------------------------------------------------------------------
  // ID/EX register
  // --------------------------------------------------------------------------

  logic               idValid;
  legPkg::doubleWordT idPc;
  legPkg::instrT      idInstr;
  legPkg::doubleWordT idSignExt;
  legPkg::doubleWordT idData1;
  legPkg::doubleWordT idData2;
  legPkg::aluSrcT     idAluSrc;
  legPkg::aluOpT      idAluOp;
  logic [6:0]         idCtrl;

  always_ff @(posedge clk)
  begin
    if (rst)
      idValid <= 1'b0;
    else
      idValid <= inValid;
  end

  always_ff @(posedge clk)
  begin
    if (inValid)
    begin
      idPc      <= pc;
      idInstr   <= instr;
      idSignExt <= signExt;
      idData1   <= readData1;
      idData2   <= readData2;
      idAluSrc  <= aluSrc;
      idAluOp   <= aluOp;
      idCtrl    <= {branch, branchZero, branchNotZero, memRead, memWrite, memToReg, regWrite};
    end
  end

  // --------------------------------------------------------------------------
  // ALU
  // --------------------------------------------------------------------------

  legPkg::aluFuncT    func;
  legPkg::doubleWordT aluB;
  legPkg::doubleWordT aluResult;

  aluControl aluCtl
  (
    .aluOp  (idAluOp),
    .opcode (idInstr[31:21]),
    .func   (func)
  );

  always_comb
  begin
    case (idAluSrc)
      2'd1:    aluB = idSignExt;
      2'd2:    aluB = {52'd0, idInstr[21:10]};
      default: aluB = idData2;
    endcase
  end

  always_comb
  begin
    case (func)
      legPkg::aluAnd:   aluResult = idData1 & aluB;
      legPkg::aluOrr:   aluResult = idData1 | aluB;
      legPkg::aluSub:   aluResult = idData1 - aluB;
      legPkg::aluPassB: aluResult = aluB;
      default:          aluResult = idData1 + aluB;
    endcase
  end

  // --------------------------------------------------------------------------
  // EX/MEM register
  // --------------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (rst)
      exValid <= 1'b0;
    else
      exValid <= idValid;
  end

  always_ff @(posedge clk)
  begin
    if (idValid)
    begin
      exInstrReg     <= idInstr[4:0];
      exResult       <= aluResult;
      exStoreData    <= idData2;
      exZero         <= (aluResult == '0);
      exBranchTarget <= idPc + (idSignExt << 2);
      {exBranch, exBranchZero, exBranchNotZero, exMemRead, exMemWrite, exMemToReg,
        exRegWrite} <= idCtrl;
    end
  end

endmodule

// File: rtl/legBackEnd.sv
`timescale 1ns/1ps

module legBackEnd
(
  input  logic               clk,
  input  logic               rst,
  input  logic               inValid,
  input  legPkg::doubleWordT pc,
  input  legPkg::instrT      instr,
  input  legPkg::doubleWordT signExt,
  input  legPkg::doubleWordT readData1,
  input  legPkg::doubleWordT readData2,
  input  legPkg::aluSrcT     aluSrc,
  input  legPkg::aluOpT      aluOp,
  input  logic               branch,
  input  logic               branchZero,
  input  logic               branchNotZero,
  input  logic               memRead,
  input  logic               memWrite,
  input  logic               memToReg,
  input  logic               regWrite,
  output logic               wbValid,
  output logic               wbWrite,
  output legPkg::regIdT      wbReg,
  output legPkg::doubleWordT wbData,
  output logic               branchValid,
  output logic               branchTaken,
  output legPkg::doubleWordT branchTarget
);

  // EX/MEM bundle between the two stages
  logic               exValid;
  legPkg::regIdT      exInstrReg;
  legPkg::doubleWordT exResult;
  legPkg::doubleWordT exStoreData;
  logic               exZero;
  legPkg::doubleWordT exBranchTarget;
  logic               exBranch;
  logic               exBranchZero;
  logic               exBranchNotZero;
  logic               exMemRead;
  logic               exMemWrite;
  logic               exMemToReg;
  logic               exRegWrite;

  executeStage exStage
  (
    .clk             (clk),
    .rst             (rst),
    .inValid         (inValid),
    .pc              (pc),
    .instr           (instr),
    .signExt         (signExt),
    .readData1       (readData1),
    .readData2       (readData2),
    .aluSrc          (aluSrc),
    .aluOp           (aluOp),
    .branch          (branch),
    .branchZero      (branchZero),
    .branchNotZero   (branchNotZero),
    .memRead         (memRead),
    .memWrite        (memWrite),
    .memToReg        (memToReg),
    .regWrite        (regWrite),
    .exValid         (exValid),
    .exInstrReg      (exInstrReg),
    .exResult        (exResult),
    .exStoreData     (exStoreData),
    .exZero          (exZero),
    .exBranchTarget  (exBranchTarget),
    .exBranch        (exBranch),
    .exBranchZero    (exBranchZero),
    .exBranchNotZero (exBranchNotZero),
    .exMemRead       (exMemRead),
    .exMemWrite      (exMemWrite),
    .exMemToReg      (exMemToReg),
    .exRegWrite      (exRegWrite)
  );

  memoryAccess memStage
  (
    .clk             (clk),
    .rst             (rst),
    .exValid         (exValid),
    .exInstrReg      (exInstrReg),
    .exResult        (exResult),
    .exStoreData     (exStoreData),
    .exZero          (exZero),
    .exBranchTarget  (exBranchTarget),
    .exBranch        (exBranch),
    .exBranchZero    (exBranchZero),
    .exBranchNotZero (exBranchNotZero),
    .exMemRead       (exMemRead),
    .exMemWrite      (exMemWrite),
    .exMemToReg      (exMemToReg),
    .exRegWrite      (exRegWrite),
    .wbValid         (wbValid),
    .wbWrite         (wbWrite),
    .wbReg           (wbReg),
    .wbData          (wbData),
    .branchValid     (branchValid),
    .branchTaken     (branchTaken),
    .branchTarget    (branchTarget)
  );

endmodule

// File: rtl/legPkg.sv
package legPkg;

  // --------------------------------------------------------------------------
  // Datapath widths
  // --------------------------------------------------------------------------

  // Data, addresses and extended immediates are all one doubleword
  typedef logic [63:0] doubleWordT;

  typedef logic [31:0] instrT;

  // Register index, also the destination field in instruction bits 4 to 0
  typedef logic [4:0] regIdT;

  // --------------------------------------------------------------------------
  // Decode control fields
  // --------------------------------------------------------------------------

  // Second ALU operand: 0 readData2, 1 signExt, 2 zero-extended imm12, 3 as 0
  typedef logic [1:0] aluSrcT;

  // Operation class: 0 address add, 1 pass-B, 2 R-type, 3 I-type
  typedef logic [1:0] aluOpT;

  typedef enum logic [3:0]
  {
    aluAnd   = 4'b0000,
    aluOrr   = 4'b0001,
    aluAdd   = 4'b0010,
    aluSub   = 4'b0110,
    aluPassB = 4'b0111
  } aluFuncT;

  // --------------------------------------------------------------------------
  // Data memory
  // --------------------------------------------------------------------------

  // Doubleword count, indexed by address bits 8 to 3
  localparam int memWords = 64;

endpackage

// File: rtl/memoryAccess.sv
`timescale 1ns/1ps

module memoryAccess
(
  input  logic               clk,
  input  logic               rst,
  input  logic               exValid,
  input  legPkg::regIdT      exInstrReg,
  input  legPkg::doubleWordT exResult,
  input  legPkg::doubleWordT exStoreData,
  input  logic               exZero,
  input  legPkg::doubleWordT exBranchTarget,
  input  logic               exBranch,
  input  logic               exBranchZero,
  input  logic               exBranchNotZero,
  input  logic               exMemRead,
  input  logic               exMemWrite,
  input  logic               exMemToReg,
  input  logic               exRegWrite,
  output logic               wbValid,
  output logic               wbWrite,
  output legPkg::regIdT      wbReg,
  output legPkg::doubleWordT wbData,
  output logic               branchValid,
  output logic               branchTaken,
  output legPkg::doubleWordT branchTarget
);

  // --------------------------------------------------------------------------
  // Data memory
  // --------------------------------------------------------------------------

  legPkg::doubleWordT                  mem [legPkg::memWords];
  logic [$clog2(legPkg::memWords)-1:0] memIdx;
  legPkg::doubleWordT                  loadData;
  logic                                taken;

  // Doubleword aligned, so the low three address bits are dropped
  assign memIdx = exResult[$clog2(legPkg::memWords)+2:3];

  always_ff @(posedge clk)
  begin
    if (exValid && exMemWrite)
      mem[memIdx] <= exStoreData;
  end

  // Read is combinational so a store in the previous cycle is already visible
  assign loadData = exMemRead ? mem[memIdx] : '0;

  assign taken = exBranch | (exBranchZero & exZero) | (exBranchNotZero & ~exZero);

  // --------------------------------------------------------------------------
  // MEM/WB output register
  // --------------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wbValid     <= 1'b0;
      wbWrite     <= 1'b0;
      branchValid <= 1'b0;
      branchTaken <= 1'b0;
    end
    else
    begin
      wbValid     <= exValid;
      wbWrite     <= exValid & exRegWrite;
      branchValid <= exValid;
      branchTaken <= exValid & taken;
    end
  end

  always_ff @(posedge clk)
  begin
    if (exValid)
    begin
      wbReg        <= exInstrReg;
      wbData       <= exMemToReg ? loadData : exResult;
      branchTarget <= exBranchTarget;
    end
  end

endmodule

// File: test/legBackEndTb.sv
`timescale 1ns/1ps

module legBackEndTb;

  localparam int resetCycles = 5;
  localparam logic [10:0] rOps [4] = '{11'b10001011000, 11'b11001011000,
                                       11'b10001010000, 11'b10101010000};
  localparam logic [9:0]  iOps [4] = '{10'b1001000100, 10'b1101000100,
                                       10'b1001001000, 10'b1011001000};
  localparam logic [10:0] sturOp = 11'b11111000000;
  localparam logic [10:0] ldurOp = 11'b11111000010;

  typedef struct packed
  {
    logic               write;
    legPkg::regIdT      dest;
    legPkg::doubleWordT data;
    logic               taken;
    legPkg::doubleWordT target;
    int                 cycle;
  } expectT;

  logic               clk;
  logic               rst;
  logic               inValid;
  legPkg::doubleWordT pc;
  legPkg::instrT      instr;
  legPkg::doubleWordT signExt;
  legPkg::doubleWordT readData1;
  legPkg::doubleWordT readData2;
  legPkg::aluSrcT     aluSrc;
  legPkg::aluOpT      aluOp;
  logic               branch;
  logic               branchZero;
  logic               branchNotZero;
  logic               memRead;
  logic               memWrite;
  logic               memToReg;
  logic               regWrite;
  logic               wbValid;
  logic               wbWrite;
  legPkg::regIdT      wbReg;
  legPkg::doubleWordT wbData;
  logic               branchValid;
  logic               branchTaken;
  legPkg::doubleWordT branchTarget;

  expectT             expQ [$];
  expectT             head;
  legPkg::doubleWordT mirror [legPkg::memWords];
  logic [31:0]        seed;
  int                 cycles = 0;
  int                 issued = 0;
  int                 errors = 0;
  int                 testBase = 0;
  int                 testsRun = 0;

  legBackEnd UUT (.*);

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
    cycles <= cycles + 1;

  // --------------------------------------------------------------------------
  // Reference model and stimulus
  // --------------------------------------------------------------------------

  function automatic logic [31:0] nextRandom();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  function automatic legPkg::doubleWordT randomWord();
    return {nextRandom(), nextRandom()};
  endfunction

  function automatic legPkg::doubleWordT modelAlu(input legPkg::aluOpT op,
    input legPkg::instrT ins, input legPkg::doubleWordT a, input legPkg::doubleWordT b);
    legPkg::doubleWordT res;
    res = a + b;
    case (op)
      2'd1: res = b;
      2'd2:
        case (ins[31:21])
          11'b11001011000: res = a - b;
          11'b10001010000: res = a & b;
          11'b10101010000: res = a | b;
          default:         res = a + b;
        endcase
      2'd3:
        case (ins[31:22])
          10'b1101000100: res = a - b;
          10'b1001001000: res = a & b;
          10'b1011001000: res = a | b;
          default:        res = a + b;
        endcase
      default: res = a + b;
    endcase
    return res;
  endfunction

  // ctrl is {branch, branchZero, branchNotZero, memRead, memWrite, memToReg, regWrite}
  task automatic issue(input legPkg::doubleWordT pcIn, input legPkg::instrT ins,
    input legPkg::doubleWordT sext, input legPkg::doubleWordT a,
    input legPkg::doubleWordT b, input legPkg::aluSrcT src, input legPkg::aluOpT op,
    input logic [6:0] ctrl);
    expectT             e;
    legPkg::doubleWordT opB;
    legPkg::doubleWordT res;
    logic [5:0]         idx;
    @(posedge clk);
    case (src)
      2'd1:    opB = sext;
      2'd2:    opB = {52'd0, ins[21:10]};
      default: opB = b;
    endcase
    res = modelAlu(op, ins, a, opB);
    idx = res[8:3];
    e.write = ctrl[0];
    e.dest = ins[4:0];
    e.data = res;
    if (ctrl[1])
      e.data = ctrl[3] ? mirror[idx] : '0;
    if (ctrl[2])
      mirror[idx] = b;
    e.taken = ctrl[6] | (ctrl[5] & (res == '0)) | (ctrl[4] & (res != '0));
    e.target = pcIn + sext * 64'd4;
    e.cycle = cycles + 1;
    expQ.push_back(e);
    issued++;
    inValid <= 1'b1;
    pc <= pcIn;
    instr <= ins;
    signExt <= sext;
    readData1 <= a;
    readData2 <= b;
    aluSrc <= src;
    aluOp <= op;
    {branch, branchZero, branchNotZero, memRead, memWrite, memToReg, regWrite} <= ctrl;
  endtask

  task automatic drain();
    @(posedge clk);
    inValid <= 1'b0;
    while (expQ.size() != 0)
      @(posedge clk);
  endtask

  task automatic reportTest(input string name);
    int fails;
    fails = errors - testBase;
    testBase = errors;
    testsRun++;
    $display("Test %-8s done, %0d errors", name, fails);
  endtask

  // --------------------------------------------------------------------------
  // Compare and monitor
  // --------------------------------------------------------------------------

  task automatic compareWb(input logic write, input legPkg::regIdT dest,
    input legPkg::doubleWordT data);
    if (wbWrite !== write || wbReg !== dest || wbData !== data)
    begin
      errors++;
      $display("MISMATCH at %0t: writeback %b r%0d %h, expected %b r%0d %h",
               $time, wbWrite, wbReg, wbData, write, dest, data);
    end
  endtask

  task automatic compareBranch(input logic taken, input legPkg::doubleWordT target);
    if (branchTaken !== taken || branchTarget !== target)
    begin
      errors++;
      $display("MISMATCH at %0t: branch %b %h, expected %b %h",
               $time, branchTaken, branchTarget, taken, target);
    end
  endtask

  always @(negedge clk)
  begin
    if (!rst && (wbValid || branchValid))
    begin
      if (expQ.size() == 0)
      begin
        errors++;
        $display("Output appeared at %0t with no instruction in flight", $time);
      end
      else
      begin
        head = expQ.pop_front();
        if (!(wbValid && branchValid))
        begin
          errors++;
          $display("wbValid and branchValid did not fire together at %0t", $time);
        end
        if (cycles != head.cycle + 3)
        begin
          errors++;
          $display("MISMATCH at %0t: result in cycle %0d, expected cycle %0d",
                   $time, cycles, head.cycle + 3);
        end
        compareWb(head.write, head.dest, head.data);
        compareBranch(head.taken, head.target);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------

  task automatic latencyTest();
    // The monitor flags any output seen while idle
    repeat (6) @(posedge clk);
    issue(64'h400, {rOps[0], 16'h0, 5'd1}, '0, 64'd5, 64'd7, 2'd0, 2'd2, 7'b0000001);
    drain();
    reportTest("latency");
  endtask

  task automatic rTypeTest();
    logic [31:0] r;
    for (int i = 0; i < 4; i++)
    begin
      r = nextRandom();
      issue(randomWord(), {rOps[i], r[15:0], r[20:16]}, randomWord(), randomWord(),
            randomWord(), 2'd0, 2'd2, 7'b0000001);
    end
    issue(randomWord(), {11'b11111111111, 16'h0, 5'd7}, randomWord(), randomWord(),
          randomWord(), 2'd0, 2'd2, 7'b0000001);
    drain();
    reportTest("rType");
  endtask

  task automatic immTest();
    logic [31:0] r;
    for (int i = 0; i < 4; i++)
    begin
      r = nextRandom();
      issue(randomWord(), {iOps[i], r[11:0], r[16:12], r[21:17]}, randomWord(),
            randomWord(), randomWord(), 2'd2, 2'd3, 7'b0000001);
    end
    issue(randomWord(), {iOps[0], 12'hfff, 5'd2, 5'd4}, 64'hffff_ffff_ffff_ff38,
          randomWord(), randomWord(), 2'd1, 2'd3, 7'b0000001);
    issue(randomWord(), {iOps[1], 12'h010, 5'd2, 5'd6}, 64'd100, randomWord(),
          randomWord(), 2'd1, 2'd3, 7'b0000001);
    drain();
    reportTest("imm");
  endtask

  task automatic memTest();
    legPkg::doubleWordT valA;
    legPkg::doubleWordT valB;
    valA = randomWord();
    valB = randomWord();
    issue(64'h100, {sturOp, 16'h0, 5'd1}, 64'd16, 64'h200, valA, 2'd1, 2'd0, 7'b0000100);
    issue(64'h104, {ldurOp, 16'h0, 5'd5}, 64'd16, 64'h200, '0, 2'd1, 2'd0, 7'b0001011);
    issue(64'h108, {sturOp, 16'h0, 5'd2}, 64'd40, 64'h200, valB, 2'd1, 2'd0, 7'b0000100);
    issue(64'h10c, {ldurOp, 16'h0, 5'd6}, 64'd16, 64'h200, '0, 2'd1, 2'd0, 7'b0001011);
    issue(64'h110, {ldurOp, 16'h0, 5'd7}, 64'd40, 64'h200, '0, 2'd1, 2'd0, 7'b0001011);
    drain();
    reportTest("mem");
  endtask

  task automatic branchTest();
    legPkg::doubleWordT nz;
    nz = randomWord() | 64'd1;
    issue(randomWord(), 32'h1400_0010, 64'd16, randomWord(), randomWord(), 2'd0, 2'd1,
          7'b1000000);
    issue(randomWord(), 32'hb400_0043, 64'hffff_ffff_ffff_fff0, '0, '0, 2'd0, 2'd1,
          7'b0100000);
    issue(randomWord(), 32'hb400_0043, 64'd8, '0, nz, 2'd0, 2'd1, 7'b0100000);
    issue(randomWord(), 32'hb500_0043, 64'd12, '0, '0, 2'd0, 2'd1, 7'b0010000);
    issue(randomWord(), 32'hb500_0043, 64'hffff_ffff_ffff_ff00, '0, nz, 2'd0, 2'd1,
          7'b0010000);
    drain();
    reportTest("branch");
  endtask

  task automatic streamTest();
    logic [31:0]        r;
    legPkg::doubleWordT addr;
    for (int i = 0; i < 12; i++)
    begin
      r = nextRandom();
      addr = {55'd0, r[7:2], 3'd0};
      case (r[1:0])
        2'd0:
          issue(randomWord(), {rOps[r[3:2]], r[31:16], r[8:4]}, randomWord(),
                randomWord(), randomWord(), 2'd0, 2'd2, 7'b0000001);
        2'd1:
          issue(randomWord(), {iOps[r[3:2]], r[15:4], r[20:16], r[25:21]}, randomWord(),
                randomWord(), randomWord(), 2'd2, 2'd3, 7'b0000001);
        2'd2:
        begin
          issue(randomWord(), {sturOp, 16'h0, 5'd0}, addr, '0, randomWord(), 2'd1, 2'd0,
                7'b0000100);
          issue(randomWord(), {ldurOp, 16'h0, r[12:8]}, addr, '0, '0, 2'd1, 2'd0,
                7'b0001011);
        end
        default:
          issue(randomWord(), {8'b10110100, r[26:8], r[31:27]}, {{46{r[31]}}, r[31:14]},
                randomWord(), r[4] ? '0 : randomWord(), 2'd0, 2'd1,
                r[5] ? 7'b0100000 : 7'b0010000);
      endcase
    end
    drain();
    reportTest("stream");
  endtask

  // --------------------------------------------------------------------------
  // Run control
  // --------------------------------------------------------------------------

  initial
  begin
    while (cycles <= 40 * (issued + 1) + resetCycles)
      @(posedge clk);
    $display("Timeout after %0d cycles with %0d results outstanding", cycles, expQ.size());
    $display("Verification failed");
    $finish;
  end

  initial
  begin
    seed = 32'hf0630c71;
    rst = 1'b1;
    inValid = 1'b0;
    pc = '0;
    instr = '0;
    signExt = '0;
    readData1 = '0;
    readData2 = '0;
    aluSrc = '0;
    aluOp = '0;
    branch = 1'b0;
    branchZero = 1'b0;
    branchNotZero = 1'b0;
    memRead = 1'b0;
    memWrite = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    repeat (resetCycles) @(posedge clk);
    rst <= 1'b0;
    latencyTest();
    rTypeTest();
    immTest();
    memTest();
    branchTest();
    streamTest();
    $display("Tests %0d, instructions %0d, errors %0d", testsRun, issued, errors);
    if (errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// File: test/legBackEnd_checker.sv
`timescale 1ns/1ps

module legBackEnd_checker
(
  input logic               clk,
  input logic               rst,
  input logic               inValid,
  input logic               wbValid,
  input logic               branchValid,
  input legPkg::doubleWordT wbData
);

  // Every strobe leaves the pipeline exactly three edges later
  latencyA: assert property (@(posedge clk) disable iff (rst)
    wbValid == $past(inValid, 3))
    else $error("wbValid does not follow inValid by three cycles");

  pairA: assert property (@(posedge clk) disable iff (rst)
    branchValid == wbValid)
    else $error("branchValid and wbValid differ");

  knownA: assert property (@(posedge clk) disable iff (rst)
    wbValid |-> !$isunknown(wbData))
    else $error("wbData has unknown bits while wbValid is high");

  quietA: assert property (@(posedge clk)
    rst |=> (!wbValid && !branchValid))
    else $error("Outputs active during reset");

endmodule

bind legBackEnd legBackEnd_checker chk (.*);
